// ==== verilog/dbg_defs.svh ====
`ifndef DBG_DEFS_SVH
`define DBG_DEFS_SVH

// Data memory depth in 32-bit words.
`define DBG_MEM_WORDS 256

// Cycles from the start of a memory access to its completion pulse.
`define DBG_MEM_LATENCY 3

// PC of the core stub when it leaves reset.
`define DBG_RESET_PC 32'h0000_1000

`endif

// ==== verilog/dbg_pkg.sv ====
package dbg_pkg;

	typedef enum logic [3:0] {
		CMD_HALT      = 4'h0,
		CMD_RUN       = 4'h1,
		CMD_STEP      = 4'h2,
		CMD_READ_REG  = 4'h3,
		CMD_WRITE_REG = 4'h4,
		CMD_RMEM32    = 4'h5,
		CMD_RMEM16    = 4'h6,
		CMD_RMEM8     = 4'h7,
		CMD_WMEM32    = 4'h8,
		CMD_WMEM16    = 4'h9,
		CMD_WMEM8     = 4'ha
	} dbg_cmd_t;

	typedef enum logic [3:0] {
		ST_IDLE         = 4'b0000,
		ST_LOAD_CMD     = 4'b0001,
		ST_LOAD_ADDR    = 4'b0010,
		ST_LOAD_DATA    = 4'b0011,
		ST_WAIT_STOPPED = 4'b0100,
		ST_STEP         = 4'b0101,
		ST_COMPLETE     = 4'b0110,
		ST_STORE_REG    = 4'b0111,
		ST_EXECUTE      = 4'b1000,
		ST_WAIT_MEM_WR  = 4'b1100,
		ST_WAIT_MEM_RD  = 4'b1110,
		ST_WRITE_REG    = 4'b1111
	} dbg_state_t;

	typedef enum logic [1:0] {
		MEM_BYTE = 2'd0,
		MEM_HALF = 2'd1,
		MEM_WORD = 2'd2
	} mem_width_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wr_val;
		mem_width_t  width;
		logic        wr_en;
		logic        access;
	} mem_req_t;

	// Bit 3 of sel picks the PC instead of a general register.
	typedef struct packed {
		logic [3:0]  sel;
		logic [31:0] wr_val;
		logic        reg_wr_en;
		logic        pc_wr_en;
	} reg_req_t;

	typedef struct packed {
		logic [1:0]  addr;
		logic [31:0] din;
		logic        wr_en;
	} mbox_port_t;

endpackage

// ==== verilog/dbg_mailbox.sv ====
module dbg_mailbox (
	input  logic                clk,
	input  logic                dbg_clk,
	input  logic                arst_n,
	input  logic [1:0]          host_addr,
	input  logic [31:0]         host_din,
	input  logic                host_wr,
	input  logic                req,
	input  dbg_pkg::mbox_port_t ctl,
	input  logic                ack_int,
	output logic [31:0]         host_dout,
	output logic                ack,
	output logic [31:0]         ctl_dout,
	output logic                req_sync
);

	logic [31:0] cmd_word;
	logic [31:0] addr_word;
	logic [31:0] data_word;
	logic [31:0] result_word;
	logic        req_meta;
	logic        ack_meta;

	function automatic logic [31:0] read_word(input logic [1:0] sel);
		case (sel)
		2'd0: return cmd_word;
		2'd1: return addr_word;
		2'd2: return data_word;
		default: return result_word;
		endcase
	endfunction

	// Host port. Word 3 is owned by the core side, host writes to it are dropped.
	always_ff @(posedge dbg_clk) begin
		if (host_wr) begin
			case (host_addr)
			2'd0: cmd_word <= host_din;
			2'd1: addr_word <= host_din;
			2'd2: data_word <= host_din;
			default: ;
			endcase
		end
		host_dout <= read_word(host_addr);
	end

	// Controller port.
	always_ff @(posedge clk) begin
		if (ctl.wr_en && ctl.addr == 2'd3)
			result_word <= ctl.din;
		ctl_dout <= read_word(ctl.addr);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			req_meta <= 1'b0;
			req_sync <= 1'b0;
		end else begin
			req_meta <= req;
			req_sync <= req_meta;
		end
	end

	always_ff @(posedge dbg_clk or negedge arst_n) begin
		if (!arst_n) begin
			ack_meta <= 1'b0;
			ack <= 1'b0;
		end else begin
			ack_meta <= ack_int;
			ack <= ack_meta;
		end
	end

	// The controller only ever posts results.
	a_ctl_wr_word3: assert property (@(posedge clk) disable iff (!arst_n)
		ctl.wr_en |-> ctl.addr == 2'd3);

endmodule

// ==== verilog/dbg_controller.sv ====
module dbg_controller (
	input  logic                clk,
	input  logic                arst_n,
	input  logic [31:0]         ctl_dout,
	input  logic                req_sync,
	input  logic [31:0]         reg_val,
	input  logic                stopped,
	input  logic [31:0]         mem_rd_val,
	input  logic                mem_compl,
	output dbg_pkg::mbox_port_t ctl,
	output logic                ack_int,
	output logic                run,
	output dbg_pkg::reg_req_t   reg_req,
	output dbg_pkg::mem_req_t   mem_req
);

	import dbg_pkg::*;

	dbg_state_t  state;
	dbg_state_t  next_state;
	dbg_cmd_t    cmd;
	logic [31:0] dbg_addr;
	logic [31:0] dbg_data;
	mem_width_t  mem_width;
	logic        mem_wr;

	// Access size and direction follow from the opcode alone.
	always_comb begin
		mem_width = MEM_WORD;
		mem_wr = 1'b0;
		case (cmd)
		CMD_WMEM32: mem_wr = 1'b1;
		CMD_WMEM16: begin
			mem_width = MEM_HALF;
			mem_wr = 1'b1;
		end
		CMD_WMEM8: begin
			mem_width = MEM_BYTE;
			mem_wr = 1'b1;
		end
		CMD_RMEM16: mem_width = MEM_HALF;
		CMD_RMEM8: mem_width = MEM_BYTE;
		default: ;
		endcase
	end

	always_comb begin
		next_state = state;

		ctl.addr = 2'd0;
		ctl.din = reg_val;
		ctl.wr_en = 1'b0;

		reg_req.sel = dbg_addr[3:0];
		reg_req.wr_val = dbg_data;
		reg_req.reg_wr_en = 1'b0;
		reg_req.pc_wr_en = 1'b0;

		mem_req.addr = dbg_addr;
		mem_req.wr_val = dbg_data;
		mem_req.width = mem_width;
		mem_req.wr_en = mem_wr;
		mem_req.access = 1'b0;

		case (state)
		ST_IDLE: begin
			if (req_sync)
				next_state = ST_LOAD_CMD;
		end
		ST_LOAD_CMD: begin
			ctl.addr = 2'd1;
			next_state = ST_LOAD_ADDR;
		end
		ST_LOAD_ADDR: begin
			ctl.addr = 2'd2;
			next_state = ST_LOAD_DATA;
		end
		ST_LOAD_DATA: next_state = ST_EXECUTE;
		ST_EXECUTE: begin
			case (cmd)
			CMD_HALT: next_state = ST_WAIT_STOPPED;
			CMD_RUN: next_state = ST_COMPLETE;
			CMD_STEP: next_state = ST_STEP;
			CMD_READ_REG: next_state = ST_STORE_REG;
			CMD_WRITE_REG: next_state = ST_WRITE_REG;
			CMD_RMEM32, CMD_RMEM16, CMD_RMEM8: begin
				mem_req.access = 1'b1;
				next_state = ST_WAIT_MEM_RD;
			end
			CMD_WMEM32, CMD_WMEM16, CMD_WMEM8: begin
				mem_req.access = 1'b1;
				next_state = ST_WAIT_MEM_WR;
			end
			// Unknown opcodes finish without touching anything.
			default: next_state = ST_COMPLETE;
			endcase
		end
		ST_STEP: next_state = ST_WAIT_STOPPED;
		ST_WAIT_STOPPED: begin
			if (stopped)
				next_state = ST_COMPLETE;
		end
		ST_STORE_REG: begin
			ctl.addr = 2'd3;
			ctl.wr_en = 1'b1;
			next_state = ST_COMPLETE;
		end
		ST_WRITE_REG: begin
			reg_req.pc_wr_en = dbg_addr[3];
			reg_req.reg_wr_en = ~dbg_addr[3];
			next_state = ST_COMPLETE;
		end
		ST_WAIT_MEM_RD: begin
			mem_req.access = ~mem_compl;
			if (mem_compl) begin
				ctl.addr = 2'd3;
				ctl.din = mem_rd_val;
				ctl.wr_en = 1'b1;
				next_state = ST_COMPLETE;
			end
		end
		ST_WAIT_MEM_WR: begin
			mem_req.access = ~mem_compl;
			if (mem_compl)
				next_state = ST_COMPLETE;
		end
		ST_COMPLETE: begin
			if (!req_sync)
				next_state = ST_IDLE;
		end
		default: next_state = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			cmd <= CMD_HALT;
			run <= 1'b1;
			ack_int <= 1'b0;
		end else begin
			state <= next_state;
			// Registered so the ack synchronizer samples a clean flop.
			ack_int <= (next_state == ST_COMPLETE);
			if (state == ST_LOAD_CMD)
				cmd <= dbg_cmd_t'(ctl_dout[3:0]);
			if (state == ST_EXECUTE) begin
				case (cmd)
				CMD_HALT: run <= 1'b0;
				CMD_RUN, CMD_STEP: run <= 1'b1;
				default: ;
				endcase
			end
			if (state == ST_STEP)
				run <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_LOAD_ADDR)
			dbg_addr <= ctl_dout;
		if (state == ST_LOAD_DATA)
			dbg_data <= ctl_dout;
	end

	a_one_wr_strobe: assert property (@(posedge clk) disable iff (!arst_n)
		!(reg_req.reg_wr_en && reg_req.pc_wr_en));

	a_access_states: assert property (@(posedge clk) disable iff (!arst_n)
		mem_req.access |-> state inside {ST_EXECUTE, ST_WAIT_MEM_RD, ST_WAIT_MEM_WR});

	a_ack_complete: assert property (@(posedge clk) disable iff (!arst_n)
		ack_int |-> state == ST_COMPLETE);

endmodule

// ==== verilog/core_stub.sv ====
`include "dbg_defs.svh"

module core_stub (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              run,
	input  dbg_pkg::reg_req_t reg_req,
	output logic [31:0]       reg_val,
	output logic              stopped
);

	logic [31:0] gpr [8];
	logic [31:0] pc;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 8; i++)
				gpr[i] <= '0;
		end else if (reg_req.reg_wr_en) begin
			gpr[reg_req.sel[2:0]] <= reg_req.wr_val;
		end
	end

	// A debugger write to the PC wins over the run advance.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= `DBG_RESET_PC;
		end else if (reg_req.pc_wr_en) begin
			pc <= reg_req.wr_val;
		end else if (run) begin
			pc <= pc + 32'd4;
		end
	end

	// Stopped lags run by a cycle, like a pipeline draining.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			stopped <= 1'b0;
		else
			stopped <= ~run;
	end

	assign reg_val = reg_req.sel[3] ? pc : gpr[reg_req.sel[2:0]];

endmodule

// ==== verilog/data_mem.sv ====
`include "dbg_defs.svh"

module data_mem (
	input  logic              clk,
	input  logic              arst_n,
	input  dbg_pkg::mem_req_t req,
	output logic [31:0]       rd_val,
	output logic              compl
);

	import dbg_pkg::*;

	localparam int IDX_W = $clog2(`DBG_MEM_WORDS);
	localparam int LAT = `DBG_MEM_LATENCY;
	localparam int CNT_W = $clog2(LAT + 1);

	logic [31:0]      mem [`DBG_MEM_WORDS];
	logic [IDX_W-1:0] idx;
	logic [CNT_W-1:0] cnt;
	logic             last;
	logic [31:0]      rd_word;
	logic [31:0]      wdata;
	logic [3:0]       be;

	assign idx = req.addr[IDX_W+1:2];
	assign last = (cnt == CNT_W'(LAT - 1));
	assign rd_word = mem[idx];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
			compl <= 1'b0;
		end else begin
			compl <= 1'b0;
			if (req.access) begin
				cnt <= last ? '0 : cnt + 1'b1;
				compl <= last;
			end
		end
	end

	// Narrow writes replicate the data so every lane sees it.
	always_comb begin
		be = 4'b1111;
		wdata = req.wr_val;
		case (req.width)
		MEM_BYTE: begin
			be = 4'b0001 << req.addr[1:0];
			wdata = {4{req.wr_val[7:0]}};
		end
		MEM_HALF: begin
			be = req.addr[1] ? 4'b1100 : 4'b0011;
			wdata = {2{req.wr_val[15:0]}};
		end
		default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (req.access && req.wr_en && last) begin
			for (int i = 0; i < 4; i++) begin
				if (be[i])
					mem[idx][8*i +: 8] <= wdata[8*i +: 8];
			end
		end
	end

	always_comb begin
		case (req.width)
		MEM_BYTE: rd_val = {24'h0, rd_word[8*req.addr[1:0] +: 8]};
		MEM_HALF: rd_val = {16'h0, rd_word[16*req.addr[1] +: 16]};
		default: rd_val = rd_word;
		endcase
	end

	a_aligned: assert property (@(posedge clk) disable iff (!arst_n)
		req.access |-> (req.width == MEM_HALF) ? !req.addr[0] :
			(req.width == MEM_WORD) ? req.addr[1:0] == 2'b00 : 1'b1);

endmodule

// ==== verilog/dbg_top.sv ====
module dbg_top (
	input  logic        clk,
	input  logic        dbg_clk,
	input  logic        arst_n,
	input  logic [1:0]  host_addr,
	input  logic [31:0] host_din,
	input  logic        host_wr,
	input  logic        req,
	output logic [31:0] host_dout,
	output logic        ack
);

	import dbg_pkg::*;

	mbox_port_t  ctl;
	logic [31:0] ctl_dout;
	logic        req_sync;
	logic        ack_int;
	logic        run;
	reg_req_t    reg_req;
	logic [31:0] reg_val;
	logic        stopped;
	mem_req_t    mem_req;
	logic [31:0] mem_rd_val;
	logic        mem_compl;

	dbg_mailbox u_mailbox (
		.clk       (clk),
		.dbg_clk   (dbg_clk),
		.arst_n    (arst_n),
		.host_addr (host_addr),
		.host_din  (host_din),
		.host_wr   (host_wr),
		.req       (req),
		.ctl       (ctl),
		.ack_int   (ack_int),
		.host_dout (host_dout),
		.ack       (ack),
		.ctl_dout  (ctl_dout),
		.req_sync  (req_sync)
	);

	dbg_controller u_controller (
		.clk        (clk),
		.arst_n     (arst_n),
		.ctl_dout   (ctl_dout),
		.req_sync   (req_sync),
		.reg_val    (reg_val),
		.stopped    (stopped),
		.mem_rd_val (mem_rd_val),
		.mem_compl  (mem_compl),
		.ctl        (ctl),
		.ack_int    (ack_int),
		.run        (run),
		.reg_req    (reg_req),
		.mem_req    (mem_req)
	);

	core_stub u_core (
		.clk     (clk),
		.arst_n  (arst_n),
		.run     (run),
		.reg_req (reg_req),
		.reg_val (reg_val),
		.stopped (stopped)
	);

	data_mem u_mem (
		.clk    (clk),
		.arst_n (arst_n),
		.req    (mem_req),
		.rd_val (mem_rd_val),
		.compl  (mem_compl)
	);

endmodule

// ==== verification/tb_clock.sv ====
module tb_clock #(
	parameter int PERIOD_NS = 10
) (
	output logic clk
);

	timeunit 1ns;
	timeprecision 100ps;

	// Free-running clock, low for the first half period.
	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2);
			clk = ~clk;
		end
	end

endmodule

// ==== verification/tb_dbg_top.sv ====
`include "dbg_defs.svh"

module tb_dbg_top;

	timeunit 1ns;
	timeprecision 100ps;

	import dbg_pkg::*;

	localparam int ACK_WAIT = 100;
	localparam int WD_CYCLES_PER_ENTRY = 200;

	typedef enum logic [2:0] {
		CHK_NONE,
		CHK_KEEP,
		CHK_EXP,
		CHK_SAME,
		CHK_DELTA,
		CHK_RESET
	} check_t;

	typedef struct packed {
		logic [3:0]  cmd;
		logic [31:0] addr;
		logic [31:0] data;
		check_t      chk;
		logic [31:0] exp;
	} entry_t;

	logic        clk;
	logic        dbg_clk;
	logic        arst_n;
	logic [1:0]  host_addr;
	logic [31:0] host_din;
	logic        host_wr;
	logic        req;
	logic [31:0] host_dout;
	logic        ack;

	entry_t      tbl[$];
	logic [31:0] ref_gpr [8];
	logic [31:0] ref_pc;
	logic [7:0]  ref_mem [`DBG_MEM_WORDS * 4];
	logic [31:0] last_rd;
	integer      seed;
	bit          table_ready;
	int          checks;
	int          value_errors;
	int          protocol_errors;
	int          timeouts;

	tb_clock #(.PERIOD_NS(10)) u_clk_gen (.clk(clk));
	tb_clock #(.PERIOD_NS(16)) u_dbg_clk_gen (.clk(dbg_clk));

	dbg_top u_dbg_top (
		.clk       (clk),
		.dbg_clk   (dbg_clk),
		.arst_n    (arst_n),
		.host_addr (host_addr),
		.host_din  (host_din),
		.host_wr   (host_wr),
		.req       (req),
		.host_dout (host_dout),
		.ack       (ack)
	);

	function automatic logic [31:0] next_rand();
		return $random(seed);
	endfunction

	function automatic int access_bytes(input logic [3:0] cmd);
		case (cmd)
		CMD_RMEM8, CMD_WMEM8: return 1;
		CMD_RMEM16, CMD_WMEM16: return 2;
		default: return 4;
		endcase
	endfunction

	task automatic add_entry(input logic [3:0] cmd, input logic [31:0] addr,
			input logic [31:0] data, input check_t chk, input logic [31:0] exp);
		entry_t e;
		e.cmd = cmd;
		e.addr = addr;
		e.data = data;
		e.chk = chk;
		e.exp = exp;
		tbl.push_back(e);
	endtask

	task automatic reg_write(input logic [3:0] sel, input logic [31:0] val);
		if (sel[3])
			ref_pc = val;
		else
			ref_gpr[sel[2:0]] = val;
		add_entry(CMD_WRITE_REG, {28'h0, sel}, val, CHK_NONE, '0);
	endtask

	task automatic reg_read(input logic [3:0] sel);
		add_entry(CMD_READ_REG, {28'h0, sel}, '0, CHK_EXP,
			sel[3] ? ref_pc : ref_gpr[sel[2:0]]);
	endtask

	// Little-endian lanes: byte i of the value goes to address addr + i.
	task automatic mem_write(input logic [3:0] cmd, input logic [31:0] addr,
			input logic [31:0] val);
		int base;
		base = int'(addr);
		for (int i = 0; i < access_bytes(cmd); i++)
			ref_mem[base + i] = val[8*i +: 8];
		add_entry(cmd, addr, val, CHK_NONE, '0);
	endtask

	task automatic mem_read(input logic [3:0] cmd, input logic [31:0] addr);
		logic [31:0] exp;
		int base;
		exp = '0;
		base = int'(addr);
		for (int i = 0; i < access_bytes(cmd); i++)
			exp[8*i +: 8] = ref_mem[base + i];
		add_entry(cmd, addr, '0, CHK_EXP, exp);
	endtask

	task automatic build_table();
		logic [31:0] base_a;
		logic [31:0] top_a;
		logic [31:0] v;
		base_a = 32'h0000_0040;
		top_a = 32'((`DBG_MEM_WORDS - 1) * 4);
		ref_pc = `DBG_RESET_PC;
		for (int r = 0; r < 8; r++)
			ref_gpr[r] = '0;

		// Core runs out of reset, so the first halt lands past the reset PC.
		add_entry(CMD_HALT, '0, '0, CHK_NONE, '0);
		add_entry(CMD_READ_REG, 32'h8, '0, CHK_RESET, '0);
		add_entry(CMD_READ_REG, 32'h8, '0, CHK_SAME, '0);
		add_entry(CMD_READ_REG, 32'h8, '0, CHK_SAME, '0);
		for (int i = 0; i < 2; i++) begin
			add_entry(CMD_STEP, '0, '0, CHK_NONE, '0);
			add_entry(CMD_READ_REG, 32'h8, '0, CHK_DELTA, 32'd4);
		end

		v = next_rand();
		reg_write(4'h8, {v[31:2], 2'b00});
		reg_read(4'h8);
		add_entry(CMD_STEP, '0, '0, CHK_NONE, '0);
		ref_pc = ref_pc + 32'd4;
		reg_read(4'h8);
		for (int r = 0; r < 8; r++)
			reg_write(4'(r), next_rand());
		for (int r = 0; r < 8; r++)
			reg_read(4'(r));

		mem_write(CMD_WMEM32, base_a, next_rand());
		mem_read(CMD_RMEM32, base_a);
		mem_write(CMD_WMEM8, base_a + 1, next_rand());
		mem_read(CMD_RMEM32, base_a);
		mem_read(CMD_RMEM8, base_a + 1);
		mem_read(CMD_RMEM8, base_a + 3);
		mem_write(CMD_WMEM16, base_a + 2, next_rand());
		mem_read(CMD_RMEM16, base_a + 2);
		mem_read(CMD_RMEM16, base_a);
		mem_read(CMD_RMEM32, base_a);
		mem_write(CMD_WMEM32, base_a + 4, next_rand());
		mem_write(CMD_WMEM8, base_a + 7, next_rand());
		mem_read(CMD_RMEM32, base_a + 4);
		mem_read(CMD_RMEM8, base_a + 6);
		mem_write(CMD_WMEM32, top_a, next_rand());
		mem_read(CMD_RMEM8, top_a + 3);
		mem_read(CMD_RMEM16, top_a + 2);
		mem_read(CMD_RMEM32, top_a);

		// Unused opcodes aimed at memory, the PC and a register.
		add_entry(4'hc, base_a, next_rand(), CHK_NONE, '0);
		add_entry(4'hf, 32'h8, next_rand(), CHK_NONE, '0);
		add_entry(4'hb, 32'h3, next_rand(), CHK_NONE, '0);
		reg_read(4'h8);
		reg_read(4'h3);
		mem_read(CMD_RMEM32, base_a);

		add_entry(CMD_RUN, '0, '0, CHK_NONE, '0);
		reg_read(4'h5);
		add_entry(CMD_HALT, '0, '0, CHK_NONE, '0);
		add_entry(CMD_READ_REG, 32'h8, '0, CHK_KEEP, '0);
		add_entry(CMD_READ_REG, 32'h8, '0, CHK_SAME, '0);
	endtask

	// Full four-phase exchange. Outputs are sampled on the falling edge.
	task automatic run_exchange(input entry_t e, output logic [31:0] rd, output bit ok);
		int waited;
		ok = 1'b1;
		rd = '0;
		@(posedge dbg_clk);
		host_wr <= 1'b1;
		host_addr <= 2'd0;
		host_din <= {28'h0, e.cmd};
		@(posedge dbg_clk);
		host_addr <= 2'd1;
		host_din <= e.addr;
		@(posedge dbg_clk);
		host_addr <= 2'd2;
		host_din <= e.data;
		@(posedge dbg_clk);
		host_wr <= 1'b0;
		host_addr <= 2'd3;
		req <= 1'b1;
		waited = 0;
		@(negedge dbg_clk);
		// Two synchronizers lie between req and ack, so ack is still low here.
		assert (!ack) else begin
			$display("ack was already high when req rose for command %h", e.cmd);
			protocol_errors++;
			ok = 1'b0;
		end
		if (!ok)
			return;
		while (!ack && waited < ACK_WAIT) begin
			@(negedge dbg_clk);
			waited++;
		end
		assert (ack) else begin
			$display("timeout: ack did not rise for command %h", e.cmd);
			timeouts++;
			ok = 1'b0;
		end
		if (!ok)
			return;
		rd = host_dout;
		@(posedge dbg_clk);
		req <= 1'b0;
		waited = 0;
		@(negedge dbg_clk);
		while (ack && waited < ACK_WAIT) begin
			@(negedge dbg_clk);
			waited++;
		end
		assert (!ack) else begin
			$display("timeout: ack stayed high after req dropped, command %h", e.cmd);
			timeouts++;
			ok = 1'b0;
		end
	endtask

	task automatic check_result(input entry_t e, input logic [31:0] rd);
		logic [31:0] exp;
		case (e.chk)
		CHK_EXP: exp = e.exp;
		CHK_SAME: exp = last_rd;
		CHK_DELTA: exp = last_rd + e.exp;
		default: exp = rd;
		endcase
		if (e.chk == CHK_RESET) begin
			checks++;
			assert (rd != `DBG_RESET_PC && rd[1:0] == 2'(`DBG_RESET_PC)) else begin
				$display("error host_dout exp aligned PC past %h got %h",
					`DBG_RESET_PC, rd);
				value_errors++;
			end
		end else if (e.chk != CHK_NONE && e.chk != CHK_KEEP) begin
			checks++;
			assert (rd === exp) else begin
				$display("error host_dout exp %h got %h", exp, rd);
				value_errors++;
			end
		end
		if (e.chk != CHK_NONE)
			last_rd = rd;
	endtask

	task automatic report_counts();
		$display("checks %0d, value errors %0d, protocol errors %0d, timeouts %0d",
			checks, value_errors, protocol_errors, timeouts);
	endtask

	initial begin
		logic [31:0] rd;
		bit ok;
		bit aborted;
		arst_n <= 1'b0;
		host_addr <= 2'd0;
		host_din <= '0;
		host_wr <= 1'b0;
		req <= 1'b0;
		seed = 32'h955eb5a1;
		aborted = 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
		repeat (2) @(posedge dbg_clk);
		for (int i = 0; i < tbl.size() && !aborted; i++) begin
			run_exchange(tbl[i], rd, ok);
			if (!ok)
				aborted = 1'b1;
			else
				check_result(tbl[i], rd);
		end
		report_counts();
		if (value_errors == 0 && protocol_errors == 0 && timeouts == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// Watchdog sized from the number of table entries.
	initial begin
		wait (table_ready);
		repeat (tbl.size() * WD_CYCLES_PER_ENTRY) @(posedge dbg_clk);
		$display("watchdog expired before the command table finished");
		timeouts++;
		report_counts();
		$display("sim failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+verilog
verilog/dbg_pkg.sv
verilog/dbg_mailbox.sv
verilog/dbg_controller.sv
verilog/core_stub.sv
verilog/data_mem.sv
verilog/dbg_top.sv
verification/tb_clock.sv
verification/tb_dbg_top.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_dbg_top \
	--Mdir obj_dir -o tb_dbg_top -f filelist.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_dbg_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "sim failed" "$LOG"; then
	exit 1
fi
exit 0
